/* run_sim.sh */
#!/bin/sh
# Build and run the vs_filter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_vs_filter -f tb.f

out=$(./obj_dir/Vtb_vs_filter)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

/* sim/tb_vs_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vs_filter_macros.svh"

module tb_vs_filter;

    logic                      clk;
    logic                      reset;
    logic                      vs_in;
    logic                      filter_en;
    vs_status_pkg::match_cnt_t filter_times;
    vs_timing_pkg::tolerance_t filter_threshold;
    logic                      vs_out;
    logic                      vs_stable;

    integer seed;
    int     check_errors;
    int     timeouts;
    int     gap_waited;
    string  test_name;

    // Reference model, in the vs_in time frame
    int     m_now;
    int     m_last;
    int     m_ref;
    int     m_match;
    logic   m_armed;
    logic   m_has_ref;
    logic   m_stable;
    logic   m_vs_d;
    logic [2:0] exp_pipe;
    logic   vs_in_d1;
    logic   vs_in_d2;
    logic   fen_d1;
    logic   exp_vs_out;

    vs_filter vs_filter_inst (
        .clk              (clk),
        .reset            (reset),
        .vs_in            (vs_in),
        .filter_en        (filter_en),
        .filter_times     (filter_times),
        .filter_threshold (filter_threshold),
        .vs_out           (vs_out),
        .vs_stable        (vs_stable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // One measured period against the judge rule
    task judge_period(input int len);
        int diff;
        diff = (len > m_ref) ? (len - m_ref) : (m_ref - len);
        if (!m_has_ref) begin
            m_has_ref = 1'b1;
            m_match   = 0;
        end else if (diff <= int'(filter_threshold)) begin
            if (m_match < 15) begin
                m_match = m_match + 1;
            end
            if (m_match >= int'(filter_times)) begin
                m_stable = 1'b1;
            end
        end else begin
            m_match  = 0;
            m_stable = 1'b0;
        end
        m_ref = len;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            m_now     = 0;
            m_last    = 0;
            m_ref     = 0;
            m_match   = 0;
            m_armed   = 1'b0;
            m_has_ref = 1'b0;
            m_stable  = 1'b0;
            m_vs_d    = 1'b0;
            exp_pipe <= '0;
        end else begin
            m_now = m_now + 1;
            if (m_vs_d && !vs_in) begin
                if (m_armed) begin
                    judge_period(m_now - m_last);
                end
                m_armed = 1'b1;
                m_last  = m_now;
            end else if (m_armed && (m_now - m_last) == `VS_TIMEOUT_CYCLES) begin
                m_armed   = 1'b0;
                m_has_ref = 1'b0;
                m_match   = 0;
                m_stable  = 1'b0;
            end
            m_vs_d = vs_in;
            // Synchronizer plus judge register put the DUT 2 cycles behind
            exp_pipe <= {exp_pipe[1:0], m_stable};
        end
    end

    always @(posedge clk) begin
        vs_in_d1 <= vs_in;
        vs_in_d2 <= vs_in_d1;
        fen_d1   <= filter_en;
    end

    assign exp_vs_out = vs_in_d2 & (~fen_d1 | exp_pipe[2]);

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_stable_model: assert property (
        @(posedge clk) disable iff (reset)
        vs_stable == exp_pipe[2]
    ) else begin
        check_errors++;
        $display("error %s vs_stable expected %0b actual %0b", test_name,
                 $sampled(exp_pipe[2]), $sampled(vs_stable));
    end

    a_pass_through: assert property (
        @(posedge clk) disable iff (reset)
        vs_out == exp_vs_out
    ) else begin
        check_errors++;
        $display("error %s vs_out expected %0b actual %0b", test_name,
                 $sampled(exp_vs_out), $sampled(vs_out));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Two cycles high, then low up to the next pulse
    task automatic send_period(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            vs_in <= (i < 2);
        end
    endtask

    task automatic send_jittered(input int base, input int count);
        int j;
        for (int n = 0; n < count; n++) begin
            j = $unsigned($random(seed)) % 5;
            send_period(base + j);
        end
    endtask

    task automatic check_stable(input logic exp, input string name);
        @(negedge clk);
        test_name = name;
        assert (vs_stable === exp) else begin
            check_errors++;
            $display("error %s vs_stable expected %0b actual %0b", name, exp, vs_stable);
        end
    endtask

    task automatic wait_stable(input logic exp, input int max_cycles, input string name,
                               output int waited);
        int n;
        n = 0;
        while (vs_stable !== exp && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        waited = n;
        if (vs_stable !== exp) begin
            timeouts++;
            $display("%s: vs_stable did not reach %0b within %0d cycles", name, exp, max_cycles);
        end
    endtask

    initial begin
        seed             = 32'hfaab;
        check_errors     = 0;
        timeouts         = 0;
        test_name        = "reset";
        reset            = 1'b1;
        vs_in            = 1'b0;
        filter_en        = 1'b1;
        filter_times     = 4'd3;
        filter_threshold = 16'd5;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (10) @(posedge clk);
        check_stable(1'b0, "after_reset");

        test_name = "becoming_stable";
        send_jittered(200, 4);
        check_stable(1'b0, "becoming_stable_early");
        send_jittered(200, 1);
        check_stable(1'b1, "becoming_stable");

        // The long period is measured at the following edge
        test_name = "wrong_period";
        send_jittered(250, 1);
        send_jittered(200, 1);
        check_stable(1'b0, "wrong_period_drop");
        send_jittered(200, 3);
        check_stable(1'b0, "wrong_period_pending");
        send_jittered(200, 1);
        check_stable(1'b1, "wrong_period_recover");

        test_name = "tolerance";
        send_period(200);
        send_period(205);
        send_period(211);
        check_stable(1'b1, "tolerance_5");
        send_period(200);
        check_stable(1'b0, "tolerance_6");
        send_period(200);
        send_period(200);
        send_period(200);
        send_period(200);
        check_stable(1'b1, "tolerance_recover");

        test_name = "sync_loss";
        send_period(3);
        wait_stable(1'b0, 4500, "sync_loss", gap_waited);
        repeat (5000 - 3 - gap_waited) @(posedge clk);
        send_jittered(200, 4);
        check_stable(1'b0, "sync_loss_pending");
        send_jittered(200, 1);
        check_stable(1'b1, "sync_loss_recover");

        // Filter off, vs_out follows vs_in while unstable
        test_name = "filter_off";
        @(posedge clk);
        filter_en <= 1'b0;
        send_jittered(260, 1);
        send_jittered(200, 1);
        check_stable(1'b0, "filter_off_unstable");
        send_jittered(200, 2);
        repeat (10) @(posedge clk);

        $display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/vs_timing_pkg.sv
verilog/vs_status_pkg.sv
verilog/vs_period_meter.sv
verilog/vs_stability_judge.sv
verilog/vs_filter.sv
sim/tb_vs_filter.sv

/* verilog/vs_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vs_filter_macros.svh"

module vs_filter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        vs_in,
    input  logic                        filter_en,
    input  vs_status_pkg::match_cnt_t   filter_times,
    input  vs_timing_pkg::tolerance_t   filter_threshold,
    output logic                        vs_out,
    output logic                        vs_stable
);

    // Meter to judge
    logic                   vs_sync;
    logic                   period_valid;
    vs_timing_pkg::period_t period;
    logic                   sync_lost;

    vs_period_meter vs_period_meter_inst (
        .clk          (clk),
        .reset        (reset),
        .vs_in        (vs_in),
        .vs_sync      (vs_sync),
        .period_valid (period_valid),
        .period       (period),
        .sync_lost    (sync_lost)
    );

    vs_stability_judge vs_stability_judge_inst (
        .clk              (clk),
        .reset            (reset),
        .vs_sync          (vs_sync),
        .period_valid     (period_valid),
        .period           (period),
        .sync_lost        (sync_lost),
        .filter_en        (filter_en),
        .filter_times     (filter_times),
        .filter_threshold (filter_threshold),
        .vs_out           (vs_out),
        .vs_stable        (vs_stable)
    );

endmodule

`default_nettype wire

/* verilog/vs_filter_macros.svh */
`ifndef VS_FILTER_MACROS_SVH
`define VS_FILTER_MACROS_SVH

// Width of the period counter and of every cycle count derived from it
`define VS_CNT_W 16

// Cycles without a falling edge before the sync is considered lost
`define VS_TIMEOUT_CYCLES 4096

// Flops in the vs input synchronizer
`define VS_SYNC_STAGES 2

`endif

/* verilog/vs_period_meter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vs_filter_macros.svh"

module vs_period_meter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   vs_in,
    output logic                   vs_sync,
    output logic                   period_valid,
    output vs_timing_pkg::period_t period,
    output logic                   sync_lost
);

    logic [`VS_SYNC_STAGES-1:0] sync_sr;
    logic                       vs_sync_d;
    logic                       fall_edge;
    logic                       have_edge;
    logic                       at_timeout;
    vs_timing_pkg::period_t     cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_sr   <= '0;
            vs_sync_d <= 1'b0;
        end else begin
            sync_sr   <= {sync_sr[`VS_SYNC_STAGES-2:0], vs_in};
            vs_sync_d <= vs_sync;
        end
    end

    assign vs_sync   = sync_sr[`VS_SYNC_STAGES-1];
    assign fall_edge = vs_sync_d & ~vs_sync;

    ////////////////////////////////////////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////////////////////////////////////////

    assign at_timeout = (cnt == vs_timing_pkg::period_t'(`VS_TIMEOUT_CYCLES));

    // Restart at 1 on the edge itself, so cnt holds the full period
    // when the next edge arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= '0;
            have_edge <= 1'b0;
        end else if (fall_edge) begin
            cnt       <= vs_timing_pkg::period_t'(1);
            have_edge <= 1'b1;
        end else if (have_edge) begin
            if (at_timeout) begin
                // Frozen until the next edge
                have_edge <= 1'b0;
            end else begin
                cnt <= cnt + vs_timing_pkg::period_t'(1);
            end
        end
    end

    // First edge after reset or loss only arms the counter
    assign period_valid = fall_edge & have_edge;
    assign period       = cnt;
    assign sync_lost    = have_edge & at_timeout & ~fall_edge;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // The judge handles one event per cycle
    a_pulses_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(period_valid && sync_lost)
    ) else $error("period_valid and sync_lost high in the same cycle");

    a_period_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        period_valid |-> (period != '0)
    ) else $error("zero period reported");

endmodule

`default_nettype wire

/* verilog/vs_stability_judge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vs_filter_macros.svh"

module vs_stability_judge (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        vs_sync,
    input  logic                        period_valid,
    input  vs_timing_pkg::period_t      period,
    input  logic                        sync_lost,
    input  logic                        filter_en,
    input  vs_status_pkg::match_cnt_t   filter_times,
    input  vs_timing_pkg::tolerance_t   filter_threshold,
    output logic                        vs_out,
    output logic                        vs_stable
);

    vs_status_pkg::judge_state_t state;
    vs_status_pkg::judge_state_t state_nxt;
    vs_status_pkg::match_cnt_t   match_cnt;
    vs_status_pkg::match_cnt_t   match_nxt;
    vs_status_pkg::match_cnt_t   match_inc;
    vs_timing_pkg::period_t      ref_period;
    logic [`VS_CNT_W-1:0]        period_diff;
    logic                        agree;
    logic                        pass_en;

    ////////////////////////////////////////////////////////////////////////////
    // Period comparison
    ////////////////////////////////////////////////////////////////////////////

    // Absolute difference against the last period
    assign period_diff = (period >= ref_period) ? (period - ref_period)
                                                : (ref_period - period);
    assign agree       = (period_diff <= filter_threshold);

    // Saturating increment
    assign match_inc = (match_cnt == '1) ? match_cnt
                                         : match_cnt + vs_status_pkg::match_cnt_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Judge FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        match_nxt = match_cnt;
        if (sync_lost) begin
            state_nxt = vs_status_pkg::st_no_ref;
            match_nxt = '0;
        end else if (period_valid) begin
            if (state == vs_status_pkg::st_no_ref) begin
                // Nothing to compare yet, just take the reference
                state_nxt = vs_status_pkg::st_tracking;
                match_nxt = '0;
            end else if (agree) begin
                match_nxt = match_inc;
                if (match_inc >= filter_times) begin
                    state_nxt = vs_status_pkg::st_stable;
                end
            end else begin
                state_nxt = vs_status_pkg::st_tracking;
                match_nxt = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= vs_status_pkg::st_no_ref;
            match_cnt <= '0;
            pass_en   <= 1'b0;
        end else begin
            state     <= state_nxt;
            match_cnt <= match_nxt;
            pass_en   <= ~filter_en | (state_nxt == vs_status_pkg::st_stable);
        end
    end

    // New period is always the next reference, agreeing or not
    always_ff @(posedge clk) begin
        if (period_valid) begin
            ref_period <= period;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    assign vs_stable = (state == vs_status_pkg::st_stable);

    // No added delay here, vs_out lines up with vs_sync
    assign vs_out = vs_sync & pass_en;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_stable_has_matches: assert property (
        @(posedge clk) disable iff (reset)
        vs_stable |-> (match_cnt != '0)
    ) else $error("stable with zero match count");

    // Stability only ends on a measured period or a lost sync
    a_leave_stable_on_event: assert property (
        @(posedge clk) disable iff (reset)
        (state == vs_status_pkg::st_stable) && !period_valid && !sync_lost
            |=> (state == vs_status_pkg::st_stable)
    ) else $error("left stable state without period or sync loss");

endmodule

`default_nettype wire

/* verilog/vs_status_pkg.sv */
`default_nettype none

package vs_status_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stability judge status
    ////////////////////////////////////////////////////////////////////////////

    // Consecutive agreeing periods, saturates at all ones
    typedef logic [3:0] match_cnt_t;

    // st_no_ref waits for a first period to compare against,
    // st_tracking holds one but has not seen enough agreements yet
    typedef enum logic [1:0] {
        st_no_ref,
        st_tracking,
        st_stable
    } judge_state_t;

endpackage

`default_nettype wire

/* verilog/vs_timing_pkg.sv */
`default_nettype none

`include "vs_filter_macros.svh"

package vs_timing_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle counts
    ////////////////////////////////////////////////////////////////////////////

    // Length of one vs period, falling edge to falling edge
    typedef logic [`VS_CNT_W-1:0] period_t;

    // Largest period difference still taken as agreement
    typedef logic [`VS_CNT_W-1:0] tolerance_t;

endpackage

`default_nettype wire
